// File: logic/exec_config.svh
// Execute slice sizes
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Reservation station depth
`define EXEC_RS_ENTRIES 16

// Multiplier latency in cycles, counted from the issue edge
`define EXEC_MC_LATENCY 4

// Reorder-buffer id and data word widths
`define EXEC_ROBID_W 7
`define EXEC_XLEN 32

`endif

// File: logic/exec_pkg.sv
// Execute slice types
`include "exec_config.svh"

package exec_pkg;

  // Operand, result, or producer tag while not ready
  typedef logic [`EXEC_XLEN-1:0] word_t;

  typedef logic [`EXEC_ROBID_W-1:0] robid_t;

  // Bit 5 set means no destination
  typedef logic [5:0] rd_t;

  typedef enum logic [4:0] {
    OP_ADD   = 5'd0,
    OP_SUB   = 5'd1,
    OP_AND   = 5'd2,
    OP_OR    = 5'd3,
    OP_XOR   = 5'd4,
    OP_SLL   = 5'd5,
    OP_SRL   = 5'd6,
    OP_SRA   = 5'd7,
    OP_SLT   = 5'd8,
    OP_SLTU  = 5'd9,
    OP_MUL   = 5'd24,
    OP_MULH  = 5'd25,
    OP_MULHU = 5'd26
  } op_e;

  // Functional unit class stored with each station entry
  typedef enum logic [1:0] {
    FU_SC      = 2'd0,
    FU_MC      = 2'd1,
    FU_ILLEGAL = 2'd2
  } fu_class_e;

endpackage

// File: logic/op_decode.sv
// Opcode classifier
module op_decode import exec_pkg::*; (
  input  op_e       op,
  output fu_class_e fu_class
);

  always_comb begin
    case (op)
      // Single-cycle ALU group
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLL,
      OP_SRL,
      OP_SRA,
      OP_SLT,
      OP_SLTU: begin
        fu_class = FU_SC;
      end
      // Multiplier group
      OP_MUL,
      OP_MULH,
      OP_MULHU: begin
        fu_class = FU_MC;
      end
      // Unused codes still go to an ALU, which flags the error
      default: begin
        fu_class = FU_ILLEGAL;
      end
    endcase
  end

endmodule

// File: logic/exec_rs.sv
// Reservation station
`include "exec_config.svh"

module exec_rs import exec_pkg::*; #(
  parameter int RS_ENTRIES = `EXEC_RS_ENTRIES
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      flush,
  input  logic      ins_valid,
  input  op_e       ins_op,
  input  fu_class_e ins_class,
  input  robid_t    ins_robid,
  input  rd_t       ins_rd,
  input  logic      ins_op1ready,
  input  word_t     ins_op1,
  input  logic      ins_op2ready,
  input  word_t     ins_op2,
  output logic      ins_stall,
  output robid_t    iss_robid,
  output rd_t       iss_rd,
  output op_e       iss_op,
  output word_t     iss_op1,
  output word_t     iss_op2,
  output logic      sc0_issue,
  output logic      sc1_issue,
  output logic      mc0_issue,
  output logic      mc1_issue,
  input  logic      sc0_stall,
  input  logic      sc1_stall,
  input  logic      mc0_stall,
  input  logic      mc1_stall,
  input  logic      wb_valid,
  input  logic      wb_error,
  input  robid_t    wb_robid,
  input  rd_t       wb_rd,
  input  word_t     wb_result
);

  localparam int IDX_W = (RS_ENTRIES > 1) ? $clog2(RS_ENTRIES) : 1;
  localparam int TAG_W = $bits(robid_t);

  logic [RS_ENTRIES-1:0] rs_valid;
  logic [RS_ENTRIES-1:0] rs_op1ready;
  logic [RS_ENTRIES-1:0] rs_op2ready;
  op_e                   rs_op    [RS_ENTRIES];
  fu_class_e             rs_class [RS_ENTRIES];
  robid_t                rs_robid [RS_ENTRIES];
  rd_t                   rs_rd    [RS_ENTRIES];
  word_t                 rs_op1   [RS_ENTRIES];
  word_t                 rs_op2   [RS_ENTRIES];

  logic [RS_ENTRIES-1:0] ready_vec;
  logic                  issue_found;
  logic [IDX_W-1:0]      issue_idx;
  logic                  free_found;
  logic [IDX_W-1:0]      free_idx;
  logic [IDX_W-1:0]      ins_idx;
  logic                  issue_fire;
  logic                  ins_fire;
  logic                  wake;
  logic                  ins_op1_hit;
  logic                  ins_op2_hit;

  // Only results with a real destination wake consumers
  assign wake = wb_valid & ~wb_error & ~wb_rd[5];

  assign ready_vec = rs_valid & rs_op1ready & rs_op2ready;

  // Lowest index wins for both searches
  always_comb begin
    issue_found = 1'b0;
    issue_idx   = '0;
    free_found  = 1'b0;
    free_idx    = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        issue_found = 1'b1;
        issue_idx   = IDX_W'(i);
      end
      if (!rs_valid[i]) begin
        free_found = 1'b1;
        free_idx   = IDX_W'(i);
      end
    end
  end

  assign iss_robid = rs_robid[issue_idx];
  assign iss_rd    = rs_rd[issue_idx];
  assign iss_op    = rs_op[issue_idx];
  assign iss_op1   = rs_op1[issue_idx];
  assign iss_op2   = rs_op2[issue_idx];

  // Steering by stored class with illegal ops sent to an ALU
  always_comb begin
    sc0_issue = 1'b0;
    sc1_issue = 1'b0;
    mc0_issue = 1'b0;
    mc1_issue = 1'b0;
    if (issue_found) begin
      if (rs_class[issue_idx] == FU_MC) begin
        if (!mc0_stall) begin
          mc0_issue = 1'b1;
        end else if (!mc1_stall) begin
          mc1_issue = 1'b1;
        end
      end else begin
        if (!sc0_stall) begin
          sc0_issue = 1'b1;
        end else if (!sc1_stall) begin
          sc1_issue = 1'b1;
        end
      end
    end
  end

  assign issue_fire = sc0_issue | sc1_issue | mc0_issue | mc1_issue;

  // A full station can reuse the slot that issues this cycle
  assign ins_stall = ~free_found & ~issue_fire;
  assign ins_fire  = ins_valid & ~ins_stall & ~flush;
  assign ins_idx   = free_found ? free_idx : issue_idx;

  // Same-cycle bypass for the incoming instruction
  assign ins_op1_hit = wake & ~ins_op1ready & (ins_op1[TAG_W-1:0] == wb_robid);
  assign ins_op2_hit = wake & ~ins_op2ready & (ins_op2[TAG_W-1:0] == wb_robid);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rs_valid <= '0;
    end else begin
      if (issue_fire) begin
        rs_valid[issue_idx] <= 1'b0;
      end
      if (ins_fire) begin
        rs_valid[ins_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Wake-up of waiting operands
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (wake && !rs_op1ready[i] && rs_op1[i][TAG_W-1:0] == wb_robid) begin
        rs_op1ready[i] <= 1'b1;
        rs_op1[i]      <= wb_result;
      end
      if (wake && !rs_op2ready[i] && rs_op2[i][TAG_W-1:0] == wb_robid) begin
        rs_op2ready[i] <= 1'b1;
        rs_op2[i]      <= wb_result;
      end
    end
    if (ins_fire) begin
      rs_op[ins_idx]       <= ins_op;
      rs_class[ins_idx]    <= ins_class;
      rs_robid[ins_idx]    <= ins_robid;
      rs_rd[ins_idx]       <= ins_rd;
      rs_op1ready[ins_idx] <= ins_op1ready | ins_op1_hit;
      rs_op1[ins_idx]      <= ins_op1_hit ? wb_result : ins_op1;
      rs_op2ready[ins_idx] <= ins_op2ready | ins_op2_hit;
      rs_op2[ins_idx]      <= ins_op2_hit ? wb_result : ins_op2;
    end
  end

endmodule

// File: logic/scalu.sv
// Single-cycle integer ALU
module scalu import exec_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   issue,
  input  op_e    op,
  input  robid_t robid,
  input  rd_t    rd,
  input  word_t  op1,
  input  word_t  op2,
  input  logic   grant,
  output logic   stall,
  output logic   res_valid,
  output logic   res_error,
  output robid_t res_robid,
  output rd_t    res_rd,
  output word_t  res_value
);

  word_t      alu_value;
  logic       alu_error;
  logic [4:0] shamt;

  assign shamt = op2[4:0];

  always_comb begin
    alu_error = 1'b0;
    case (op)
      OP_ADD:  alu_value = op1 + op2;
      OP_SUB:  alu_value = op1 - op2;
      OP_AND:  alu_value = op1 & op2;
      OP_OR:   alu_value = op1 | op2;
      OP_XOR:  alu_value = op1 ^ op2;
      OP_SLL:  alu_value = op1 << shamt;
      OP_SRL:  alu_value = op1 >> shamt;
      OP_SRA:  alu_value = $signed(op1) >>> shamt;
      OP_SLT:  alu_value = word_t'($signed(op1) < $signed(op2));
      OP_SLTU: alu_value = word_t'(op1 < op2);
      default: begin
        alu_value = '0;
        alu_error = 1'b1;
      end
    endcase
  end

  // A result being granted this cycle frees the register for a new issue
  assign stall = res_valid & ~grant;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      res_valid <= 1'b0;
    end else if (issue) begin
      res_valid <= 1'b1;
    end else if (grant) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      res_error <= alu_error;
      res_robid <= robid;
      res_rd    <= rd;
      res_value <= alu_value;
    end
  end

endmodule

// File: logic/mcalu.sv
// Fixed-latency multiplier unit
`include "exec_config.svh"

module mcalu import exec_pkg::*; #(
  parameter int LATENCY = `EXEC_MC_LATENCY
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   issue,
  input  op_e    op,
  input  robid_t robid,
  input  rd_t    rd,
  input  word_t  op1,
  input  word_t  op2,
  input  logic   grant,
  output logic   stall,
  output logic   res_valid,
  output logic   res_error,
  output robid_t res_robid,
  output rd_t    res_rd,
  output word_t  res_value
);

  localparam int XLEN  = $bits(word_t);
  localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic              busy;
  logic [CNT_W-1:0]  cnt;
  logic              done;
  op_e               cap_op;
  word_t             cap_a;
  word_t             cap_b;
  logic [2*XLEN-1:0] prod_u;
  logic [2*XLEN-1:0] prod_s;

  // Full-width products sharing one low half
  assign prod_u = {{XLEN{1'b0}}, cap_a} * {{XLEN{1'b0}}, cap_b};
  assign prod_s = $signed({{XLEN{cap_a[XLEN-1]}}, cap_a}) *
                  $signed({{XLEN{cap_b[XLEN-1]}}, cap_b});

  assign done  = busy && (cnt == '0);
  assign stall = busy | res_valid;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      busy      <= 1'b0;
      cnt       <= '0;
      res_valid <= 1'b0;
    end else if (issue) begin
      busy <= 1'b1;
      cnt  <= CNT_W'(LATENCY - 1);
    end else if (done) begin
      busy      <= 1'b0;
      res_valid <= 1'b1;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
    end else if (grant) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      cap_op    <= op;
      cap_a     <= op1;
      cap_b     <= op2;
      res_robid <= robid;
      res_rd    <= rd;
    end
    // Result lands on the last busy edge
    if (done) begin
      res_error <= 1'b0;
      case (cap_op)
        OP_MUL:   res_value <= prod_u[XLEN-1:0];
        OP_MULH:  res_value <= prod_s[2*XLEN-1:XLEN];
        OP_MULHU: res_value <= prod_u[2*XLEN-1:XLEN];
        default: begin
          res_value <= '0;
          res_error <= 1'b1;
        end
      endcase
    end
  end

endmodule

// File: logic/wb_arbiter.sv
// Writeback arbiter
module wb_arbiter import exec_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   sc0_res_valid,
  input  logic   sc0_res_error,
  input  robid_t sc0_res_robid,
  input  rd_t    sc0_res_rd,
  input  word_t  sc0_res_value,
  input  logic   sc1_res_valid,
  input  logic   sc1_res_error,
  input  robid_t sc1_res_robid,
  input  rd_t    sc1_res_rd,
  input  word_t  sc1_res_value,
  input  logic   mc0_res_valid,
  input  logic   mc0_res_error,
  input  robid_t mc0_res_robid,
  input  rd_t    mc0_res_rd,
  input  word_t  mc0_res_value,
  input  logic   mc1_res_valid,
  input  logic   mc1_res_error,
  input  robid_t mc1_res_robid,
  input  rd_t    mc1_res_rd,
  input  word_t  mc1_res_value,
  output logic   sc0_grant,
  output logic   sc1_grant,
  output logic   mc0_grant,
  output logic   mc1_grant,
  output logic   wb_valid,
  output logic   wb_error,
  output robid_t wb_robid,
  output rd_t    wb_rd,
  output word_t  wb_result
);

  logic   sel_error;
  robid_t sel_robid;
  rd_t    sel_rd;
  word_t  sel_value;

  // Multipliers first since they hold off further issues while waiting
  assign mc0_grant = mc0_res_valid;
  assign mc1_grant = mc1_res_valid & ~mc0_res_valid;
  assign sc0_grant = sc0_res_valid & ~mc0_res_valid & ~mc1_res_valid;
  assign sc1_grant = sc1_res_valid & ~mc0_res_valid & ~mc1_res_valid & ~sc0_res_valid;

  always_comb begin
    if (mc0_res_valid) begin
      {sel_error, sel_robid, sel_rd, sel_value} =
        {mc0_res_error, mc0_res_robid, mc0_res_rd, mc0_res_value};
    end else if (mc1_res_valid) begin
      {sel_error, sel_robid, sel_rd, sel_value} =
        {mc1_res_error, mc1_res_robid, mc1_res_rd, mc1_res_value};
    end else if (sc0_res_valid) begin
      {sel_error, sel_robid, sel_rd, sel_value} =
        {sc0_res_error, sc0_res_robid, sc0_res_rd, sc0_res_value};
    end else begin
      {sel_error, sel_robid, sel_rd, sel_value} =
        {sc1_res_error, sc1_res_robid, sc1_res_rd, sc1_res_value};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mc0_res_valid | mc1_res_valid | sc0_res_valid | sc1_res_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_error  <= sel_error;
    wb_robid  <= sel_robid;
    wb_rd     <= sel_rd;
    wb_result <= sel_value;
  end

endmodule

// File: logic/exec_top.sv
// Out-of-order execute slice
module exec_top import exec_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   dispatch_valid,
  input  op_e    dispatch_op,
  input  robid_t dispatch_robid,
  input  rd_t    dispatch_rd,
  input  logic   dispatch_op1ready,
  input  word_t  dispatch_op1,
  input  logic   dispatch_op2ready,
  input  word_t  dispatch_op2,
  input  logic   flush,
  output logic   dispatch_stall,
  output logic   wb_valid,
  output logic   wb_error,
  output robid_t wb_robid,
  output rd_t    wb_rd,
  output word_t  wb_result
);

  fu_class_e dispatch_class;

  // Shared issue fields
  robid_t iss_robid;
  rd_t    iss_rd;
  op_e    iss_op;
  word_t  iss_op1;
  word_t  iss_op2;

  logic sc0_issue, sc1_issue, mc0_issue, mc1_issue;
  logic sc0_stall, sc1_stall, mc0_stall, mc1_stall;
  logic sc0_grant, sc1_grant, mc0_grant, mc1_grant;

  // Held results per unit
  logic   sc0_res_valid, sc1_res_valid, mc0_res_valid, mc1_res_valid;
  logic   sc0_res_error, sc1_res_error, mc0_res_error, mc1_res_error;
  robid_t sc0_res_robid, sc1_res_robid, mc0_res_robid, mc1_res_robid;
  rd_t    sc0_res_rd, sc1_res_rd, mc0_res_rd, mc1_res_rd;
  word_t  sc0_res_value, sc1_res_value, mc0_res_value, mc1_res_value;

  op_decode u_op_decode (.op(dispatch_op), .fu_class(dispatch_class));

  exec_rs u_exec_rs (
    .clk, .rst, .flush,
    .ins_valid(dispatch_valid), .ins_op(dispatch_op), .ins_class(dispatch_class),
    .ins_robid(dispatch_robid), .ins_rd(dispatch_rd),
    .ins_op1ready(dispatch_op1ready), .ins_op1(dispatch_op1),
    .ins_op2ready(dispatch_op2ready), .ins_op2(dispatch_op2),
    .ins_stall(dispatch_stall),
    .iss_robid, .iss_rd, .iss_op, .iss_op1, .iss_op2,
    .sc0_issue, .sc1_issue, .mc0_issue, .mc1_issue,
    .sc0_stall, .sc1_stall, .mc0_stall, .mc1_stall,
    .wb_valid, .wb_error, .wb_robid, .wb_rd, .wb_result
  );

  scalu u_sc0 (
    .clk, .rst, .flush, .issue(sc0_issue), .op(iss_op), .robid(iss_robid), .rd(iss_rd),
    .op1(iss_op1), .op2(iss_op2), .grant(sc0_grant), .stall(sc0_stall),
    .res_valid(sc0_res_valid), .res_error(sc0_res_error), .res_robid(sc0_res_robid),
    .res_rd(sc0_res_rd), .res_value(sc0_res_value)
  );

  scalu u_sc1 (
    .clk, .rst, .flush, .issue(sc1_issue), .op(iss_op), .robid(iss_robid), .rd(iss_rd),
    .op1(iss_op1), .op2(iss_op2), .grant(sc1_grant), .stall(sc1_stall),
    .res_valid(sc1_res_valid), .res_error(sc1_res_error), .res_robid(sc1_res_robid),
    .res_rd(sc1_res_rd), .res_value(sc1_res_value)
  );

  mcalu u_mc0 (
    .clk, .rst, .flush, .issue(mc0_issue), .op(iss_op), .robid(iss_robid), .rd(iss_rd),
    .op1(iss_op1), .op2(iss_op2), .grant(mc0_grant), .stall(mc0_stall),
    .res_valid(mc0_res_valid), .res_error(mc0_res_error), .res_robid(mc0_res_robid),
    .res_rd(mc0_res_rd), .res_value(mc0_res_value)
  );

  mcalu u_mc1 (
    .clk, .rst, .flush, .issue(mc1_issue), .op(iss_op), .robid(iss_robid), .rd(iss_rd),
    .op1(iss_op1), .op2(iss_op2), .grant(mc1_grant), .stall(mc1_stall),
    .res_valid(mc1_res_valid), .res_error(mc1_res_error), .res_robid(mc1_res_robid),
    .res_rd(mc1_res_rd), .res_value(mc1_res_value)
  );

  wb_arbiter u_wb_arbiter (
    .clk, .rst, .flush,
    .sc0_res_valid, .sc0_res_error, .sc0_res_robid, .sc0_res_rd, .sc0_res_value,
    .sc1_res_valid, .sc1_res_error, .sc1_res_robid, .sc1_res_rd, .sc1_res_value,
    .mc0_res_valid, .mc0_res_error, .mc0_res_robid, .mc0_res_rd, .mc0_res_value,
    .mc1_res_valid, .mc1_res_error, .mc1_res_robid, .mc1_res_rd, .mc1_res_value,
    .sc0_grant, .sc1_grant, .mc0_grant, .mc1_grant,
    .wb_valid, .wb_error, .wb_robid, .wb_rd, .wb_result
  );

endmodule

// File: sim/exec_props.sv
// Execute slice bound checks
module exec_props (
  input logic clk,
  input logic rst,
  input logic flush,
  input logic sc0_issue,
  input logic sc1_issue,
  input logic mc0_issue,
  input logic mc1_issue,
  input logic sc0_stall,
  input logic sc1_stall,
  input logic mc0_stall,
  input logic mc1_stall,
  input logic wb_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Station raises one strobe at most
  issue_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({sc0_issue, sc1_issue, mc0_issue, mc1_issue}))
  else begin
    $error("More than one issue strobe high in one cycle");
    fail_count++;
  end

  // Writeback bus is empty right after reset or flush
  wb_idle: assert property (@(posedge clk) (rst || flush) |=> !wb_valid)
  else begin
    $error("wb_valid high in the cycle after reset or flush");
    fail_count++;
  end

  issue_not_stalled: assert property (@(posedge clk) disable iff (rst)
    !(sc0_issue && sc0_stall) && !(sc1_issue && sc1_stall) &&
    !(mc0_issue && mc0_stall) && !(mc1_issue && mc1_stall))
  else begin
    $error("Issue strobe raised toward a stalled unit");
    fail_count++;
  end

endmodule

bind exec_top exec_props u_exec_props (
  .clk,
  .rst,
  .flush,
  .sc0_issue,
  .sc1_issue,
  .mc0_issue,
  .mc1_issue,
  .sc0_stall,
  .sc1_stall,
  .mc0_stall,
  .mc1_stall,
  .wb_valid
);

// File: sim/exec_tb.sv
// Execute slice testbench
`include "exec_config.svh"

module exec_tb import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROBIDS      = 1 << `EXEC_ROBID_W;
  localparam int MAX_IN_FLIGHT   = 24;
  localparam int NUM_RANDOM      = 400;
  localparam int NUM_CHAIN       = 24;
  localparam int MAX_PRE_FLUSH   = 40;
  localparam int NUM_POST        = 60;
  localparam int WATCHDOG_CYCLES =
    40 * (NUM_RANDOM + NUM_CHAIN + MAX_PRE_FLUSH + NUM_POST) + 1000;

  // Model slot states
  localparam int ST_FREE    = 0;
  localparam int ST_PENDING = 1;
  localparam int ST_DONE    = 2;
  localparam int ST_DEAD    = 3;

  logic   clk;
  logic   rst;
  logic   flush;
  logic   dispatch_valid;
  op_e    dispatch_op;
  robid_t dispatch_robid;
  rd_t    dispatch_rd;
  logic   dispatch_op1ready;
  word_t  dispatch_op1;
  logic   dispatch_op2ready;
  word_t  dispatch_op2;
  logic   dispatch_stall;
  logic   wb_valid;
  logic   wb_error;
  robid_t wb_robid;
  rd_t    wb_rd;
  word_t  wb_result;

  // One reference model slot per robid
  int     m_state  [NUM_ROBIDS];
  logic   m_error  [NUM_ROBIDS];
  logic   m_wakes  [NUM_ROBIDS];
  rd_t    m_rd     [NUM_ROBIDS];
  word_t  m_result [NUM_ROBIDS];

  robid_t      recent [$];
  robid_t      next_robid;
  int          in_flight;
  logic        saw_stall;
  logic        cur_wb_live;
  robid_t      cur_wb_robid;
  logic [31:0] rng;

  exec_top u_exec_top (
    .clk, .rst,
    .dispatch_valid, .dispatch_op, .dispatch_robid, .dispatch_rd,
    .dispatch_op1ready, .dispatch_op1, .dispatch_op2ready, .dispatch_op2,
    .flush, .dispatch_stall,
    .wb_valid, .wb_error, .wb_robid, .wb_rd, .wb_result
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic model_legal(input logic [4:0] code);
    return (code <= 5'd9) || (code >= 5'd24 && code <= 5'd26);
  endfunction

  function automatic word_t model_alu(input op_e op, input word_t a, input word_t b);
    logic [63:0]        prod_u;
    logic [63:0]        prod_s;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa     = a;
    sb     = b;
    prod_u = {32'd0, a} * {32'd0, b};
    prod_s = 64'(longint'(sa) * longint'(sb));
    case (op)
      OP_ADD:   return a + b;
      OP_SUB:   return a - b;
      OP_AND:   return a & b;
      OP_OR:    return a | b;
      OP_XOR:   return a ^ b;
      OP_SLL:   return a << b[4:0];
      OP_SRL:   return a >> b[4:0];
      OP_SRA:   return word_t'(sa >>> b[4:0]);
      OP_SLT:   return (sa < sb) ? 32'd1 : 32'd0;
      OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
      OP_MUL:   return prod_u[31:0];
      OP_MULH:  return prod_s[63:32];
      OP_MULHU: return prod_u[63:32];
      default:  return '0;
    endcase
  endfunction

  task automatic fail_stop();
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("MISMATCH at %0t: %s got %h expected %h (robid %0d)",
             $time, name, got, exp, wb_robid);
    fail_stop();
  endtask

  task automatic check_writeback();
    robid_t id;
    cur_wb_live = 1'b0;
    if (wb_valid === 1'b1) begin
      id = wb_robid;
      assert (m_state[id] == ST_PENDING) else begin
        $display("Robid %0d wrote back at %0t while not in flight", id, $time);
        fail_stop();
      end
      assert (wb_error === m_error[id]) else mismatch("wb_error", 32'(wb_error), 32'(m_error[id]));
      assert (wb_rd === m_rd[id]) else mismatch("wb_rd", 32'(wb_rd), 32'(m_rd[id]));
      assert (wb_result === m_result[id]) else mismatch("wb_result", wb_result, m_result[id]);
      m_state[id]  = ST_DONE;
      in_flight    = in_flight - 1;
      cur_wb_live  = m_wakes[id];
      cur_wb_robid = id;
    end
  endtask

  // Drop one-cycle strobes on the falling edge, then check the bus
  task automatic next_cycle();
    @(negedge clk);
    dispatch_valid = 1'b0;
    flush          = 1'b0;
    assert (u_exec_top.u_exec_props.fail_count == 0) else begin
      $display("A bound property of the DUT failed before %0t", $time);
      fail_stop();
    end
    check_writeback();
  endtask

  task automatic pick_operand(input logic chain, output logic rdy, output word_t drv,
                              output word_t val);
    logic [31:0] r;
    robid_t      p;
    logic        use_tag;
    r       = rand_next();
    val     = rand_next();
    drv     = val;
    rdy     = 1'b1;
    use_tag = 1'b0;
    p       = '0;
    if (recent.size() > 0) begin
      if (chain) begin
        p       = recent[$];
        use_tag = 1'b1;
      end else if (r % 3 == 0) begin
        p       = recent[(r >> 8) % recent.size()];
        use_tag = 1'b1;
      end
    end
    // Producer still pending, or on the bus this very cycle
    if (use_tag && m_wakes[p] &&
        (m_state[p] == ST_PENDING || (cur_wb_live && cur_wb_robid == p))) begin
      rdy = 1'b0;
      val = m_result[p];
      drv = {drv[`EXEC_XLEN-1:`EXEC_ROBID_W], p};
    end
  endtask

  task automatic send(input logic chain);
    logic [31:0] r;
    int          sel;
    int          x;
    logic [4:0]  code;
    robid_t      id;
    rd_t         rd;
    logic        rdy1;
    logic        rdy2;
    word_t       drv1;
    word_t       drv2;
    word_t       val1;
    word_t       val2;
    logic        legal;
    next_cycle();
    while (dispatch_stall || in_flight >= MAX_IN_FLIGHT) begin
      if (dispatch_stall) begin
        saw_stall = 1'b1;
        // A full station needs at least as many instructions in flight
        assert (in_flight >= `EXEC_RS_ENTRIES) else begin
          $display("dispatch_stall high at %0t with only %0d instructions in flight",
                   $time, in_flight);
          fail_stop();
        end
      end
      next_cycle();
    end
    r   = rand_next();
    sel = r % 20;
    x   = (r >> 8) % 19;
    if (chain) begin
      code = 5'(24 + (r >> 8) % 3);
    end else if (sel < 10) begin
      code = 5'(sel);
    end else if (sel < 17) begin
      code = 5'(24 + (r >> 8) % 3);
    end else if (x < 14) begin
      code = 5'(10 + x);
    end else begin
      code = 5'(13 + x);
    end
    // About one in eight has no destination
    rd = {!chain && r[30:28] == 3'd0, r[20:16]};
    while (m_state[next_robid] == ST_PENDING) begin
      next_robid = next_robid + 1'b1;
    end
    id         = next_robid;
    next_robid = next_robid + 1'b1;
    pick_operand(chain, rdy1, drv1, val1);
    pick_operand(1'b0, rdy2, drv2, val2);
    legal        = model_legal(code);
    m_state[id]  = ST_PENDING;
    m_error[id]  = ~legal;
    m_wakes[id]  = legal & ~rd[5];
    m_rd[id]     = rd;
    m_result[id] = legal ? model_alu(op_e'(code), val1, val2) : '0;
    in_flight    = in_flight + 1;
    recent.push_back(id);
    if (recent.size() > 6) begin
      recent.pop_front();
    end
    dispatch_valid    = 1'b1;
    dispatch_op       = op_e'(code);
    dispatch_robid    = id;
    dispatch_rd       = rd;
    dispatch_op1ready = rdy1;
    dispatch_op1      = drv1;
    dispatch_op2ready = rdy2;
    dispatch_op2      = drv2;
  endtask

  // Extra cycles catch any late or repeated writeback
  task automatic drain();
    while (in_flight > 0) begin
      next_cycle();
    end
    repeat (12) next_cycle();
  endtask

  task automatic flush_all();
    next_cycle();
    flush = 1'b1;
    for (int i = 0; i < NUM_ROBIDS; i++) begin
      if (m_state[i] == ST_PENDING) begin
        m_state[i] = ST_DEAD;
      end
    end
    in_flight = 0;
    recent.delete();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES);
    fail_stop();
  end

  initial begin
    int n_pre;
    rst               = 1'b1;
    flush             = 1'b0;
    dispatch_valid    = 1'b0;
    dispatch_op       = OP_ADD;
    dispatch_robid    = '0;
    dispatch_rd       = '0;
    dispatch_op1ready = 1'b0;
    dispatch_op1      = '0;
    dispatch_op2ready = 1'b0;
    dispatch_op2      = '0;
    rng               = 32'h377e_1d14;
    next_robid        = '0;
    in_flight         = 0;
    saw_stall         = 1'b0;
    cur_wb_live       = 1'b0;
    cur_wb_robid      = '0;
    for (int i = 0; i < NUM_ROBIDS; i++) begin
      m_state[i] = ST_FREE;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Random mix with dependencies and idle gaps
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (rand_next() % 4 == 0) begin
        repeat (1 + rand_next() % 3) next_cycle();
      end
      send(1'b0);
    end
    drain();

    // Dependent multiply chain backs up into the station
    saw_stall = 1'b0;
    for (int i = 0; i < NUM_CHAIN; i++) begin
      send(1'b1);
    end
    assert (saw_stall) else begin
      $display("dispatch_stall never rose during the multiply burst");
      fail_stop();
    end
    drain();

    // Flush with work in flight, then fresh traffic
    n_pre = 20 + rand_next() % 21;
    for (int i = 0; i < n_pre; i++) begin
      send(1'b0);
    end
    repeat (rand_next() % 4) next_cycle();
    flush_all();
    for (int i = 0; i < NUM_POST; i++) begin
      send(1'b0);
    end
    drain();

    if (u_exec_top.u_exec_props.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule

// File: filelist.f
+incdir+logic
logic/exec_pkg.sv
logic/op_decode.sv
logic/exec_rs.sv
logic/scalu.sv
logic/mcalu.sv
logic/wb_arbiter.sv
logic/exec_top.sv
sim/exec_props.sv
sim/exec_tb.sv

// File: Bender.yml
package:
  name: exec_slice

export_include_dirs:
  - logic

sources:
  - logic/exec_pkg.sv
  - logic/op_decode.sv
  - logic/exec_rs.sv
  - logic/scalu.sv
  - logic/mcalu.sv
  - logic/wb_arbiter.sv
  - logic/exec_top.sv
  - target: simulation
    files:
      - sim/exec_props.sv
      - sim/exec_tb.sv
